// ==== design/icache_pkg.sv ====
// Shared instruction cache package with geometry, bus payload structs and refill FSM states
package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // Cache and port geometry
  //////////////////////////////////////////////////////////////////////

  localparam int NB_CORES  = 2;                      // Fetch ports into the shared bank
  localparam int ADDR_W    = 32;                     // Fetch and AXI address width
  localparam int FETCH_W   = 32;                     // One instruction word
  localparam int LINE_W    = 64;                     // Cache line, same as AXI data
  localparam int NB_SETS   = 16;                     // Direct mapped, one line per set

  // Address split  | tag | index | offset |
  localparam int OFFSET_W  = $clog2(LINE_W / 8);     // Byte offset inside a line
  localparam int INDEX_W   = $clog2(NB_SETS);        // Set select
  localparam int TAG_W     = ADDR_W - INDEX_W - OFFSET_W;
  localparam int WORD_LSB  = $clog2(FETCH_W / 8);    // Lowest bit picking the word in a line

  // Single core still needs a one bit index
  localparam int CORE_ID_W = (NB_CORES > 1) ? $clog2(NB_CORES) : 1;

  // AR protection  [2] instruction  [1] secure  [0] unprivileged
  localparam logic [2:0] AXI_PROT_FETCH = 3'b100;

  //////////////////////////////////////////////////////////////////////
  // Payload types
  //////////////////////////////////////////////////////////////////////

  typedef logic [CORE_ID_W-1:0] core_id_t;           // Which fetch port issued a request

  // Request carried from the arbiter register into the bank
  typedef struct packed {
    logic [ADDR_W-1:0] addr;                         // Byte address of the fetch word
    core_id_t          core_id;                      // Requester, used to route the response
  } fetch_req_t;

  // AXI4-Lite read address channel payload
  typedef struct packed {
    logic [ADDR_W-1:0] araddr;                       // Line aligned address
    logic [2:0]        arprot;
  } axi_ar_t;

  // AXI4-Lite read data channel payload
  typedef struct packed {
    logic [LINE_W-1:0] rdata;                        // Whole line in one beat
    logic [1:0]        rresp;
  } axi_r_t;

  //////////////////////////////////////////////////////////////////////
  // Refill FSM
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    REFILL_IDLE,                                     // Waiting for a miss from the bank
    REFILL_ADDR,                                     // AR valid, waiting for arready
    REFILL_DATA                                      // R ready, waiting for rvalid
  } refill_state_e;

endpackage

// ==== design/fetch_arbiter.sv ====
// Fetch arbiter picking core requests round-robin into a registered request stage
`timescale 1ns/1ps

module fetch_arbiter (
  input  logic                                                    clk,
  input  logic                                                    rst_n,
  input  logic [icache_pkg::NB_CORES-1:0]                         fetch_req_i,
  input  logic [icache_pkg::NB_CORES-1:0][icache_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                                                    stage1_ready_i,
  output logic [icache_pkg::NB_CORES-1:0]                         fetch_gnt_o,
  output logic                                                    stage1_valid_o,
  output icache_pkg::fetch_req_t                                  stage1_req_o
);

  icache_pkg::core_id_t rr_ptr;     // Core with top priority this cycle
  icache_pkg::core_id_t ptr_next;   // One past the core granted now
  icache_pkg::core_id_t win_id;     // Selected requester
  logic                 win_found;  // Any core requesting
  logic                 accept;     // Request taken this cycle

  //////////////////////////////////////////////////////////////////////
  // Round-robin pick
  //////////////////////////////////////////////////////////////////////

  // Scan from the pointer upwards, wrapping, first requester wins
  always_comb begin
    int idx;
    win_found = 1'b0;
    win_id    = '0;
    for (int k = 0; k < icache_pkg::NB_CORES; k++) begin
      idx = (int'(rr_ptr) + k) % icache_pkg::NB_CORES;
      if (!win_found && fetch_req_i[idx]) begin
        win_found = 1'b1;
        win_id    = icache_pkg::core_id_t'(idx);
      end
    end
  end

  // A stalled bank blocks every grant, even with this register empty,
  // so the miss stall shows up at the cores as a missing gnt
  always_comb begin
    for (int i = 0; i < icache_pkg::NB_CORES; i++) begin
      fetch_gnt_o[i] = stage1_ready_i && win_found && (int'(win_id) == i);
    end
  end

  assign accept   = |fetch_gnt_o;
  assign ptr_next = (int'(win_id) == icache_pkg::NB_CORES - 1) ? '0 : win_id + 1'b1;

  //////////////////////////////////////////////////////////////////////
  // Request register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage1_valid_o <= 1'b0;
      rr_ptr         <= '0;
    end else begin
      if (stage1_ready_i) begin
        stage1_valid_o <= accept;          // Refill or drain as the bank moves
      end
      if (accept) begin
        rr_ptr <= ptr_next;                // Winner drops to lowest priority
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stage1_req_o.addr    <= fetch_addr_i[win_id];
      stage1_req_o.core_id <= win_id;      // Tag for response routing
    end
  end

  // Grants are mutually exclusive
  gnt_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(fetch_gnt_o))
    else $error("more than one fetch grant in the same cycle");

endmodule

// ==== design/icache_bank.sv ====
// Direct-mapped shared cache bank with tag compare, miss hand-off and per-core response
`timescale 1ns/1ps

module icache_bank (
  input  logic                                                     clk,
  input  logic                                                     rst_n,
  input  logic                                                     stage1_valid_i,
  input  icache_pkg::fetch_req_t                                   stage1_req_i,
  input  logic                                                     line_valid_i,
  input  logic [icache_pkg::LINE_W-1:0]                            line_data_i,
  output logic                                                     stage1_ready_o,
  output logic                                                     miss_req_o,
  output logic [icache_pkg::ADDR_W-1:0]                            miss_addr_o,
  output logic [icache_pkg::NB_CORES-1:0]                          fetch_rvalid_o,
  output logic [icache_pkg::NB_CORES-1:0][icache_pkg::FETCH_W-1:0] fetch_rdata_o
);

  // Request held in the bank stage
  logic                                                 held_valid;
  icache_pkg::fetch_req_t                               held_req;
  logic [icache_pkg::INDEX_W-1:0]                       held_index;
  logic [icache_pkg::TAG_W-1:0]                         held_tag;
  logic [icache_pkg::OFFSET_W-icache_pkg::WORD_LSB-1:0] held_word;

  // Tag and data arrays, one entry per set
  logic [icache_pkg::NB_SETS-1:0]                       valid_q;
  logic [icache_pkg::TAG_W-1:0]                         tag_q  [icache_pkg::NB_SETS];
  logic [icache_pkg::LINE_W-1:0]                        data_q [icache_pkg::NB_SETS];

  logic [icache_pkg::LINE_W-1:0]                        line_rd;   // Line at the held index
  logic [icache_pkg::FETCH_W-1:0]                       word_rd;   // Requested word of it
  logic                                                 hit;

  //////////////////////////////////////////////////////////////////////
  // Held request stage
  //////////////////////////////////////////////////////////////////////

  // Takes a new request whenever the current one finishes or none is held
  assign stage1_ready_o = !held_valid || hit;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      held_valid <= 1'b0;
    end else if (stage1_ready_o) begin
      held_valid <= stage1_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (stage1_ready_o && stage1_valid_i) begin
      held_req <= stage1_req_i;
    end
  end

  // Address split of the held fetch
  assign held_index = held_req.addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign held_tag   = held_req.addr[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
  assign held_word  = held_req.addr[icache_pkg::OFFSET_W-1:icache_pkg::WORD_LSB];

  //////////////////////////////////////////////////////////////////////
  // Lookup
  //////////////////////////////////////////////////////////////////////

  assign line_rd = data_q[held_index];
  assign hit     = held_valid && valid_q[held_index] && (tag_q[held_index] == held_tag);
  assign word_rd = line_rd[held_word * icache_pkg::FETCH_W +: icache_pkg::FETCH_W];

  // Miss stays up until the refilled line turns it into a hit
  assign miss_req_o  = held_valid && !hit;
  assign miss_addr_o = {held_req.addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
                        {icache_pkg::OFFSET_W{1'b0}}};       // Line aligned

  // Word goes out on every port, rvalid picks the owner
  always_comb begin
    for (int i = 0; i < icache_pkg::NB_CORES; i++) begin
      fetch_rvalid_o[i] = hit && (int'(held_req.core_id) == i);
      fetch_rdata_o[i]  = word_rd;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Refill write
  //////////////////////////////////////////////////////////////////////

  // Line lands in the set of the held miss, old line is evicted
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;                       // Empty cache after reset
    end else if (line_valid_i) begin
      valid_q[held_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (line_valid_i) begin
      tag_q[held_index]  <= held_tag;
      data_q[held_index] <= line_data_i;
    end
  end

  // Responses go to one core at a time
  rvalid_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(fetch_rvalid_o))
    else $error("responses to more than one core in the same cycle");

  // Miss request and its address are held until the line comes back
  miss_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    miss_req_o && !line_valid_i |=> miss_req_o && $stable(miss_addr_o))
    else $error("miss request dropped or changed before line_valid");

  // Refill master only returns lines that were asked for
  refill_wanted_a: assert property (@(posedge clk) disable iff (!rst_n)
    line_valid_i |-> miss_req_o)
    else $error("line_valid without a pending miss");

endmodule

// ==== design/refill_master.sv ====
// AXI4-Lite read master fetching one cache line from program memory per miss
`timescale 1ns/1ps

module refill_master (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          miss_req_i,
  input  logic [icache_pkg::ADDR_W-1:0] miss_addr_i,
  input  logic                          arready_i,
  input  logic                          rvalid_i,
  input  icache_pkg::axi_r_t            r_i,
  output logic                          line_valid_o,
  output logic [icache_pkg::LINE_W-1:0] line_data_o,
  output logic                          arvalid_o,
  output icache_pkg::axi_ar_t           ar_o,
  output logic                          rready_o
);

  icache_pkg::refill_state_e     state_q;
  icache_pkg::refill_state_e     state_d;
  logic [icache_pkg::ADDR_W-1:0] araddr_q;     // Line address of the running refill

  //////////////////////////////////////////////////////////////////////
  // Refill FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      icache_pkg::REFILL_IDLE: begin
        if (miss_req_i) begin
          state_d = icache_pkg::REFILL_ADDR;    // AR goes out next cycle
        end
      end
      icache_pkg::REFILL_ADDR: begin
        if (arready_i) begin
          state_d = icache_pkg::REFILL_DATA;    // Address accepted
        end
      end
      icache_pkg::REFILL_DATA: begin
        if (rvalid_i) begin
          state_d = icache_pkg::REFILL_IDLE;    // Single beat is the whole line
        end
      end
      default: begin
        state_d = icache_pkg::REFILL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= icache_pkg::REFILL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Capture the address when leaving idle, it stays fixed through the AR phase
  always_ff @(posedge clk) begin
    if (state_q == icache_pkg::REFILL_IDLE && miss_req_i) begin
      araddr_q <= miss_addr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // AXI and line outputs
  //////////////////////////////////////////////////////////////////////

  assign arvalid_o   = (state_q == icache_pkg::REFILL_ADDR);
  assign ar_o.araddr = araddr_q;
  assign ar_o.arprot = icache_pkg::AXI_PROT_FETCH;  // Always an instruction fetch
  assign rready_o    = (state_q == icache_pkg::REFILL_DATA);

  // Line handed to the bank in the R handshake cycle, rresp ignored
  assign line_valid_o = rready_o && rvalid_i;
  assign line_data_o  = r_i.rdata;

  // AR held with stable payload until the slave takes it
  ar_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid_o && !arready_i |=> arvalid_o && $stable(ar_o))
    else $error("AR valid or payload changed before arready");

endmodule

// ==== design/icache_shared_top.sv ====
// Shared instruction cache top joining arbiter, cache bank and AXI refill master
`timescale 1ns/1ps

module icache_shared_top (
  input  logic                                                     clk,
  input  logic                                                     rst_n,

  // Core fetch ports
  input  logic [icache_pkg::NB_CORES-1:0]                          fetch_req_i,
  input  logic [icache_pkg::NB_CORES-1:0][icache_pkg::ADDR_W-1:0]  fetch_addr_i,
  output logic [icache_pkg::NB_CORES-1:0]                          fetch_gnt_o,
  output logic [icache_pkg::NB_CORES-1:0]                          fetch_rvalid_o,
  output logic [icache_pkg::NB_CORES-1:0][icache_pkg::FETCH_W-1:0] fetch_rdata_o,

  // AXI4-Lite read channels to program memory
  output logic                                                     arvalid_o,
  output icache_pkg::axi_ar_t                                      ar_o,
  input  logic                                                     arready_i,
  input  logic                                                     rvalid_i,
  input  icache_pkg::axi_r_t                                       r_i,
  output logic                                                     rready_o
);

  // Arbiter register to bank
  logic                          stage1_valid;
  logic                          stage1_ready;
  icache_pkg::fetch_req_t        stage1_req;

  // Bank to refill master
  logic                          miss_req;
  logic [icache_pkg::ADDR_W-1:0] miss_addr;
  logic                          line_valid;
  logic [icache_pkg::LINE_W-1:0] line_data;

  //////////////////////////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////////////////////////

  fetch_arbiter i_fetch_arbiter (
    .clk            (clk            ),
    .rst_n          (rst_n          ),
    .fetch_req_i    (fetch_req_i    ),
    .fetch_addr_i   (fetch_addr_i   ),
    .stage1_ready_i (stage1_ready   ),
    .fetch_gnt_o    (fetch_gnt_o    ),
    .stage1_valid_o (stage1_valid   ),
    .stage1_req_o   (stage1_req     )
  );

  icache_bank i_icache_bank (
    .clk            (clk            ),
    .rst_n          (rst_n          ),
    .stage1_valid_i (stage1_valid   ),
    .stage1_req_i   (stage1_req     ),
    .line_valid_i   (line_valid     ),
    .line_data_i    (line_data      ),
    .stage1_ready_o (stage1_ready   ),
    .miss_req_o     (miss_req       ),
    .miss_addr_o    (miss_addr      ),
    .fetch_rvalid_o (fetch_rvalid_o ),
    .fetch_rdata_o  (fetch_rdata_o  )
  );

  refill_master i_refill_master (
    .clk            (clk            ),
    .rst_n          (rst_n          ),
    .miss_req_i     (miss_req       ),
    .miss_addr_i    (miss_addr      ),
    .arready_i      (arready_i      ),
    .rvalid_i       (rvalid_i       ),
    .r_i            (r_i            ),
    .line_valid_o   (line_valid     ),
    .line_data_o    (line_data      ),
    .arvalid_o      (arvalid_o      ),
    .ar_o           (ar_o           ),
    .rready_o       (rready_o       )
  );

endmodule

// ==== bench/axi_lite_mem_model.sv ====
// AXI4-Lite program memory read slave with computed line contents and random handshake delays
`timescale 1ns/1ps

module axi_lite_mem_model #(
  parameter logic [31:0] DATA_KEY = 32'h0             // Word value = byte address ^ key
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [1:0]          rnd_i,                  // [0] may raise arready  [1] may raise rvalid
  input  logic                arvalid_i,
  input  icache_pkg::axi_ar_t ar_i,
  output logic                arready_o,
  output logic                rvalid_o,
  output icache_pkg::axi_r_t  r_o,
  input  logic                rready_i
);

  logic [31:0] line_addr;     // Line of the accepted AR
  logic        addr_taken;    // AR done, R beat not raised yet

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arready_o  <= 1'b0;
      rvalid_o   <= 1'b0;
      addr_taken <= 1'b0;
      line_addr  <= '0;
      r_o        <= '0;
    end else begin
      arready_o <= 1'b0;                              // One cycle pulse
      if (arvalid_i && arready_o) begin
        addr_taken <= 1'b1;
        line_addr  <= {ar_i.araddr[31:3], 3'b000};
      end else if (arvalid_i && !addr_taken && !rvalid_o && rnd_i[0]) begin
        arready_o <= 1'b1;
      end
      // R beat held until the master takes it
      if (rvalid_o && rready_i) begin
        rvalid_o <= 1'b0;
      end else if (addr_taken && !rvalid_o && rnd_i[1]) begin
        rvalid_o   <= 1'b1;
        addr_taken <= 1'b0;
        r_o.rdata  <= {(line_addr | 32'h4) ^ DATA_KEY, line_addr ^ DATA_KEY};  // Little endian
        r_o.rresp  <= 2'b00;                          // Always OKAY
      end
    end
  end

endmodule

// ==== bench/tb_icache.sv ====
// Testbench driving two random fetch cores into the shared instruction cache with assertion checks
`timescale 1ns/1ps

module tb_icache;

  localparam int          NC        = icache_pkg::NB_CORES;
  localparam logic [31:0] LFSR_SEED = 32'h607a9d24;
  localparam logic [31:0] DATA_KEY  = 32'hc0de5a17;
  localparam logic [2:0]  PROT_INSN = 3'b100;         // Instruction, secure, unprivileged
  localparam int          NB_FETCH  = 48;             // Fetches per core
  localparam int          RUN_LIMIT = 5000;           // Cycles for issue and drain

  // Sets 0 and 9 each get two tags, set 6 stays resident
  localparam logic [31:0] ADDR_POOL [8] = '{
    32'h00000100, 32'h00000104, 32'h00002100, 32'h00000148,
    32'h0000014c, 32'h00004148, 32'h00000230, 32'h00000234
  };

  logic                clk = 1'b0;
  logic                rst_n;
  logic [NC-1:0]       fetch_req;
  logic [NC-1:0][31:0] fetch_addr;
  logic [NC-1:0]       fetch_gnt;
  logic [NC-1:0]       fetch_rvalid;
  logic [NC-1:0][31:0] fetch_rdata;
  logic                arvalid;
  logic                arready;
  logic                rvalid;
  logic                rready;
  icache_pkg::axi_ar_t ar;
  icache_pkg::axi_r_t  r;
  logic [1:0]          mem_rnd;                       // Delay bits for the memory
  logic [31:0]         lfsr_q;
  int                  issued [NC];

  // Reference model updated at grants, responses and AR handshakes
  logic [31:0]                    pend_addr [NC][8];  // Outstanding fetches with the oldest at rd
  logic                           pend_miss [NC][8];
  logic [2:0]                     pend_rd [NC];
  logic [2:0]                     pend_wr [NC];
  logic [icache_pkg::NB_SETS-1:0] shadow_valid;       // Residency once accepted fetches finish
  logic [icache_pkg::TAG_W-1:0]   shadow_tag [icache_pkg::NB_SETS];
  logic [31:0]                    miss_line [4];      // Lines still owed an AR
  logic [1:0]                     miss_rd;
  logic [1:0]                     miss_wr;
  int                             misses_open;        // Accepted misses not yet answered
  int                             ar_credit;          // ARs not yet used by a miss response
  logic [NC-1:0]                  last_gnt;

  icache_pkg::core_id_t           gnt_id;
  logic [31:0]                    gnt_addr;
  logic [icache_pkg::INDEX_W-1:0] gnt_set;
  logic                           gnt_hit;
  logic [NC-1:0]                  fast_gnt;           // Hit grant with its answer due 2 cycles later
  logic [NC-1:0]                  has_pend;
  logic [NC-1:0]                  head_miss;
  logic [NC-1:0][31:0]            exp_word;
  logic [31:0]                    miss_head;
  logic                           resp_miss;
  logic                           ar_hs;

  always #50 clk = ~clk;

  icache_shared_top dut (
    .clk            (clk         ),
    .rst_n          (rst_n       ),
    .fetch_req_i    (fetch_req   ),
    .fetch_addr_i   (fetch_addr  ),
    .fetch_gnt_o    (fetch_gnt   ),
    .fetch_rvalid_o (fetch_rvalid),
    .fetch_rdata_o  (fetch_rdata ),
    .arvalid_o      (arvalid     ),
    .ar_o           (ar          ),
    .arready_i      (arready     ),
    .rvalid_i       (rvalid      ),
    .r_i            (r           ),
    .rready_o       (rready      )
  );

  axi_lite_mem_model #(.DATA_KEY(DATA_KEY)) i_mem (
    .clk       (clk    ),
    .rst_n     (rst_n  ),
    .rnd_i     (mem_rnd),
    .arvalid_i (arvalid),
    .ar_i      (ar     ),
    .arready_o (arready),
    .rvalid_o  (rvalid ),
    .r_o       (r      ),
    .rready_i  (rready )
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // 32 bit Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
      v      = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  function automatic logic all_drained();
    logic idle;
    idle = (fetch_req == '0) && (miss_wr == miss_rd) && (misses_open == 0);
    for (int c = 0; c < NC; c++) begin
      idle = idle && (issued[c] == NB_FETCH) && (pend_wr[c] == pend_rd[c]);
    end
    return idle;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    gnt_id = '0;
    for (int c = 0; c < NC; c++) begin
      if (fetch_gnt[c]) begin
        gnt_id = icache_pkg::core_id_t'(c);
      end
      has_pend[c]  = pend_wr[c] != pend_rd[c];
      head_miss[c] = pend_miss[c][pend_rd[c]];
      exp_word[c]  = {pend_addr[c][pend_rd[c]][31:2], 2'b00} ^ DATA_KEY;  // Word address ^ key
    end
    gnt_addr  = fetch_addr[gnt_id];
    gnt_set   = gnt_addr[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    gnt_hit   = shadow_valid[gnt_set] && shadow_tag[gnt_set] == gnt_addr[31 -: icache_pkg::TAG_W];
    fast_gnt  = (gnt_hit && misses_open == 0) ? fetch_gnt : '0;   // Nothing ahead can stall
    miss_head = miss_line[miss_rd];
    resp_miss = |(fetch_rvalid & head_miss);
    ar_hs     = arvalid && arready;
  end

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      shadow_valid <= '0;                             // First fetch after reset misses
      miss_rd      <= '0;
      miss_wr      <= '0;
      misses_open  <= 0;
      ar_credit    <= 0;
      last_gnt     <= '0;
      for (int c = 0; c < NC; c++) begin
        pend_rd[c] <= '0;
        pend_wr[c] <= '0;
      end
    end else begin
      if (|fetch_gnt) begin
        pend_addr[gnt_id][pend_wr[gnt_id]] <= gnt_addr;
        pend_miss[gnt_id][pend_wr[gnt_id]] <= !gnt_hit;
        pend_wr[gnt_id]       <= pend_wr[gnt_id] + 3'd1;
        shadow_valid[gnt_set] <= 1'b1;                // Evicts any other tag in the set
        shadow_tag[gnt_set]   <= gnt_addr[31 -: icache_pkg::TAG_W];
        last_gnt              <= fetch_gnt;
        if (!gnt_hit) begin
          miss_line[miss_wr] <= {gnt_addr[31:3], 3'b000};
          miss_wr            <= miss_wr + 2'd1;
        end
      end
      for (int c = 0; c < NC; c++) begin
        if (fetch_rvalid[c]) begin
          pend_rd[c] <= pend_rd[c] + 3'd1;
        end
      end
      if (ar_hs) begin
        miss_rd <= miss_rd + 2'd1;
      end
      misses_open <= misses_open + int'(|fetch_gnt && !gnt_hit) - int'(resp_miss);
      ar_credit   <= ar_credit + int'(ar_hs) - int'(resp_miss);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  reset_idle_a: assert property (@(posedge clk)
    (!rst_n || $rose(rst_n)) |-> fetch_gnt == '0 && fetch_rvalid == '0 && !arvalid && !rready)
    else stop_on_error("Grant, response, arvalid or rready active during or right after reset");

  for (genvar c = 0; c < NC; c++) begin : g_core
    no_orphan_a: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid[c] |-> has_pend[c])
      else stop_on_error($sformatf("Response on core %0d at %0t with no fetch waiting", c, $time));
    data_a: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid[c] |-> fetch_rdata[c] == exp_word[c])
      else stop_on_error($sformatf("Mismatch at %0t: fetch_rdata_o[%0d] expected %h got %h",
                                   $time, c, $sampled(exp_word[c]), $sampled(fetch_rdata[c])));
    hit_latency_a: assert property (@(posedge clk) disable iff (!rst_n)
      $past(fast_gnt[c], 2) |-> fetch_rvalid[c])
      else stop_on_error($sformatf("Mismatch at %0t: fetch_rvalid_o[%0d] expected 1 got 0",
                                   $time, c));
  end

  // A hit that wrongly refills would raise arvalid the cycle after its response
  no_ar_on_hit_a: assert property (@(posedge clk) disable iff (!rst_n)
    $past(|fast_gnt, 3) |-> !arvalid)
    else stop_on_error($sformatf("Mismatch at %0t: arvalid_o expected 0 got 1", $time));

  // One AR per miss in acceptance order
  ar_wanted_a: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs |-> miss_wr != miss_rd)
    else stop_on_error("AR issued with no fetch miss waiting for a refill");
  ar_addr_a: assert property (@(posedge clk) disable iff (!rst_n)
    ar_hs && miss_wr != miss_rd |-> ar.araddr == miss_head)
    else stop_on_error($sformatf("Mismatch at %0t: araddr expected %h got %h",
                                 $time, $sampled(miss_head), $sampled(ar.araddr)));
  ar_prot_a: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> ar.arprot == PROT_INSN)
    else stop_on_error($sformatf("Mismatch at %0t: arprot expected %b got %b",
                                 $time, PROT_INSN, $sampled(ar.arprot)));
  ar_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(ar))
    else stop_on_error("arvalid dropped or AR payload changed before arready");
  miss_refilled_a: assert property (@(posedge clk) disable iff (!rst_n)
    resp_miss |-> ar_credit > 0)
    else stop_on_error("Fetch to a non-resident line answered without an AR refill");

  alternate_a: assert property (@(posedge clk) disable iff (!rst_n)
    (fetch_req == '1 && fetch_gnt != '0) |-> fetch_gnt != last_gnt)
    else stop_on_error("Same core granted twice in a row while the other core waited");
  stall_a: assert property (@(posedge clk) disable iff (!rst_n)
    (arvalid || rready) |-> fetch_gnt == '0)
    else stop_on_error($sformatf("Mismatch at %0t: fetch_gnt_o expected 00 got %b",
                                 $time, $sampled(fetch_gnt)));

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  initial begin
    int         cyc;
    logic [2:0] pick;
    rst_n      = 1'b0;
    fetch_req  = '0;
    fetch_addr = '0;
    mem_rnd    = '0;
    lfsr_q     = LFSR_SEED;
    for (int c = 0; c < NC; c++) begin
      issued[c] = 0;
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);                                   // One idle cycle after release
    for (cyc = 0; cyc < RUN_LIMIT && !all_drained(); cyc++) begin
      mem_rnd <= 2'(rand_bits(2));
      for (int c = 0; c < NC; c++) begin
        if (fetch_req[c] && fetch_gnt[c]) begin
          issued[c]++;
        end
        // Request and address held until granted
        if (!fetch_req[c] || fetch_gnt[c]) begin
          if (issued[c] < NB_FETCH && rand_bits(2) != 0) begin
            pick          = 3'(rand_bits(3));
            fetch_req[c]  <= 1'b1;
            fetch_addr[c] <= ADDR_POOL[pick];
          end else begin
            fetch_req[c] <= 1'b0;
          end
        end
      end
      @(posedge clk);
    end
    if (!all_drained()) begin
      stop_on_error($sformatf("Timeout after %0d cycles with fetches still outstanding", cyc));
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// ==== compile.f ====
design/icache_pkg.sv
design/fetch_arbiter.sv
design/icache_bank.sv
design/refill_master.sv
design/icache_shared_top.sv
bench/axi_lite_mem_model.sv
bench/tb_icache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the shared instruction cache testbench with Verilator and run it
set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_icache --Mdir "$BUILD_DIR" -o sim_icache \
  -f compile.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_icache"
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi
exit 0
